// ==== Bender.yml ====
package:
  name: mem_issue

sources:
  - mem_sched_pkg.sv
  - bundle_fifo.sv
  - reg_ready_table.sv
  - memory_scheduler.sv
  - mem_exec_unit.sv
  - mem_issue_top.sv
  - target: test
    files:
      - tb_mem_issue.sv

// ==== bundle_fifo.sv ====
`timescale 1ns/1ps

module bundle_fifo import mem_sched_pkg::*; #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = QUEUE_DEPTH
) (
  input  logic     cpu_clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t pop_data_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             full_q;
  logic             empty_q;
  logic             do_push;
  logic             do_pop;

  // Pushes into a full queue and pops from an empty one have no effect
  assign do_push = push_i & !full_q;
  assign do_pop  = pop_i & !empty_q;

  // Occupancy after this cycle's push and pop
  always_comb begin
    case ({do_push, do_pop})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // Pointers wrap explicitly so depths that are not a power of two work
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i | flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q   <= cnt_d;
      // Status levels come straight from flops
      full_q  <= (cnt_d == CNT_W'(DEPTH));
      empty_q <= (cnt_d == '0);
    end
  end

  // Storage array
  always_ff @(posedge cpu_clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Head entry is read combinationally so a write shows up one cycle later
  assign pop_data_o = mem_q[rd_ptr_q];
  assign full_o     = full_q;
  assign empty_o    = empty_q;

  // The consumer must look at empty before it pops
  a_no_pop_empty: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
    pop_i |-> !empty_q);

endmodule

// ==== flist.f ====
mem_sched_pkg.sv
bundle_fifo.sv
reg_ready_table.sv
memory_scheduler.sv
mem_exec_unit.sv
mem_issue_top.sv
tb_mem_issue.sv

// ==== mem_exec_unit.sv ====
`timescale 1ns/1ps

module mem_exec_unit import mem_sched_pkg::*; (
  input  logic     cpu_clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  // Op from the scheduler
  input  logic     op_vld_i,
  input  meu_op_t  op_i,
  output logic     busy_o,
  // Completion report
  output logic     cmp_vld_o,
  output meu_cmp_t cmp_o
);

  logic       busy_q;
  logic [1:0] cnt_q;
  logic       cmp_vld_q;
  logic       accept;
  logic       done;
  meu_cmp_t   cmp_q;

  // An op is taken only while the unit is idle
  assign accept = op_vld_i & !busy_q;

  // The last busy cycle is the one where the counter has run out
  assign done = busy_q & (cnt_q == 2'd0);

  // Latency is one cycle plus the two low opcode bits
  // The counter is loaded with latency minus one and counts down while busy
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i | flush_i) begin
      busy_q    <= 1'b0;
      cnt_q     <= 2'd0;
      cmp_vld_q <= 1'b0;
    end else begin
      // Completion is a single cycle pulse on the edge that ends busy
      cmp_vld_q <= done;
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q  <= op_i.ios_opcode[1:0];
      end else if (done) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Completion payload is captured with the op and held until the next one
  always_ff @(posedge cpu_clk_i) begin
    if (accept) begin
      cmp_q.tag   <= op_i.tag;
      cmp_q.dest  <= op_i.dest;
      cmp_q.store <= op_i.ios_type[STORE_BIT];
    end
  end

  // A flush clears busy and the pending pulse so the held op never completes
  assign busy_o    = busy_q;
  assign cmp_vld_o = cmp_vld_q;
  assign cmp_o     = cmp_q;

  // Back to back completions are impossible since each op spends a busy cycle
  a_cmp_one_cycle: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
    cmp_vld_q |=> !cmp_vld_q);

endmodule

// ==== mem_issue_top.sv ====
`timescale 1ns/1ps

module mem_issue_top import mem_sched_pkg::*; (
  input  logic              cpu_clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  // Renamer side
  input  logic              renamer_pkt_vld_i,
  input  mem_bundle_t       bundle_i,
  output logic              full_o,
  // Writeback from the other execution units
  input  logic              wb_vld_i,
  input  logic [PREG_W-1:0] wb_preg_i,
  // Memory unit completions
  output logic              cmp_vld_o,
  output meu_cmp_t          cmp_o
);

  mem_bundle_t       head;
  logic              empty;
  logic              pop;
  logic [PREG_W-1:0] rs1_idx;
  logic [PREG_W-1:0] rs2_idx;
  logic              rs1_rdy;
  logic              rs2_rdy;
  logic              meu_busy;
  logic              meu_vld;
  meu_op_t           meu_op;
  logic              accept;
  logic              alloc0_vld;
  logic              alloc1_vld;

  // Bundles offered while full are lost
  assign accept = renamer_pkt_vld_i & !full_o;

  // Only loads write a register so only they are marked busy
  assign alloc0_vld = accept & bundle_i.slot[0].valid & !bundle_i.slot[0].ios_type[STORE_BIT];
  assign alloc1_vld = accept & bundle_i.slot[1].valid & !bundle_i.slot[1].ios_type[STORE_BIT];

  bundle_fifo #(
    .payload_t (mem_bundle_t),
    .DEPTH     (QUEUE_DEPTH)
  ) u_bundle_fifo (
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .push_i      (accept),
    .push_data_i (bundle_i),
    .full_o      (full_o),
    .pop_i       (pop),
    .pop_data_o  (head),
    .empty_o     (empty)
  );

  // Port 0 writeback is a load completing in the memory unit
  reg_ready_table u_reg_ready_table (
    .cpu_clk_i     (cpu_clk_i),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .alloc0_vld_i  (alloc0_vld),
    .alloc0_preg_i (bundle_i.slot[0].dest),
    .alloc1_vld_i  (alloc1_vld),
    .alloc1_preg_i (bundle_i.slot[1].dest),
    .wb0_vld_i     (cmp_vld_o & !cmp_o.store),
    .wb0_preg_i    (cmp_o.dest),
    .wb1_vld_i     (wb_vld_i),
    .wb1_preg_i    (wb_preg_i),
    .rd_a_idx_i    (rs1_idx),
    .rd_a_rdy_o    (rs1_rdy),
    .rd_b_idx_i    (rs2_idx),
    .rd_b_rdy_o    (rs2_rdy)
  );

  memory_scheduler u_memory_scheduler (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .head_i     (head),
    .empty_i    (empty),
    .pop_o      (pop),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .rs1_rdy_i  (rs1_rdy),
    .rs2_rdy_i  (rs2_rdy),
    .meu_busy_i (meu_busy),
    .meu_vld_o  (meu_vld),
    .meu_op_o   (meu_op)
  );

  mem_exec_unit u_mem_exec_unit (
    .cpu_clk_i (cpu_clk_i),
    .rst_i     (rst_i),
    .flush_i   (flush_i),
    .op_vld_i  (meu_vld),
    .op_i      (meu_op),
    .busy_o    (meu_busy),
    .cmp_vld_o (cmp_vld_o),
    .cmp_o     (cmp_o)
  );

endmodule

// ==== mem_sched_pkg.sv ====
package mem_sched_pkg;

  // Physical register file sizing
  localparam int unsigned PREG_W = 6;
  localparam int unsigned NUM_PREGS = 64;

  // A bundle carries one ROB index and each op extends it by the slot number
  localparam int unsigned ROB_W = 5;
  localparam int unsigned TAG_W = 6;

  // Number of bundles the issue queue can hold
  localparam int unsigned QUEUE_DEPTH = 8;

  // Memory op type and opcode widths as produced by the decoder
  localparam int unsigned TYPE_W = 6;
  localparam int unsigned OPC_W = 3;
  localparam int unsigned IMM_W = 32;

  // This bit of the type field marks a store
  localparam int unsigned STORE_BIT = 3;

  // One renamed memory micro-op as it sits in a bundle slot
  typedef struct packed {
    logic [PREG_W-1:0] rs1;
    logic [PREG_W-1:0] rs2;
    logic [PREG_W-1:0] dest;
    logic [IMM_W-1:0]  immediate;
    logic [TYPE_W-1:0] ios_type;
    logic [OPC_W-1:0]  ios_opcode;
    logic              valid;
  } mem_uop_t;

  // Two slots share one ROB index and slot 0 is older than slot 1
  typedef struct packed {
    mem_uop_t [1:0]   slot;
    logic [ROB_W-1:0] rob;
  } mem_bundle_t;

  // Op handed from the scheduler to the memory execution unit
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [TYPE_W-1:0] ios_type;
    logic [OPC_W-1:0]  ios_opcode;
    logic [IMM_W-1:0]  immediate;
    logic [PREG_W-1:0] rs1;
    logic [PREG_W-1:0] rs2;
    logic [PREG_W-1:0] dest;
  } meu_op_t;

  // Completion report from the memory execution unit
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [PREG_W-1:0] dest;
    logic              store;
  } meu_cmp_t;

endpackage

// ==== memory_scheduler.sv ====
`timescale 1ns/1ps

module memory_scheduler import mem_sched_pkg::*; (
  input  logic              cpu_clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  // Head of the bundle queue
  input  mem_bundle_t       head_i,
  input  logic              empty_i,
  output logic              pop_o,
  // Readiness lookups for the current slot
  output logic [PREG_W-1:0] rs1_idx_o,
  output logic [PREG_W-1:0] rs2_idx_o,
  input  logic              rs1_rdy_i,
  input  logic              rs2_rdy_i,
  // Memory execution unit
  input  logic              meu_busy_i,
  output logic              meu_vld_o,
  output meu_op_t           meu_op_o
);

  mem_uop_t cur_uop;
  meu_op_t  issue_op;
  logic     slot0_vld;
  logic     slot1_vld;
  logic     both_vld;
  logic     none_vld;
  logic     sel_q;
  logic     sel;
  logic     is_store;
  logic     issue;
  logic     last_slot;

  assign slot0_vld = head_i.slot[0].valid;
  assign slot1_vld = head_i.slot[1].valid;
  assign both_vld  = slot0_vld & slot1_vld;
  assign none_vld  = !slot0_vld & !slot1_vld;

  // Slot 1 goes first only when slot 0 is empty
  // Otherwise the selector moves to slot 1 after slot 0 of a full bundle issues
  assign sel     = (!slot0_vld & slot1_vld) | sel_q;
  assign cur_uop = sel ? head_i.slot[1] : head_i.slot[0];

  // Stores also need their data register while loads ignore rs2
  assign is_store  = cur_uop.ios_type[STORE_BIT];
  assign rs1_idx_o = cur_uop.rs1;
  assign rs2_idx_o = cur_uop.rs2;

  // An op waiting in the output register counts as occupying the unit
  // because the unit only raises busy one edge after it takes the op
  assign issue = !empty_i & cur_uop.valid & rs1_rdy_i & (rs2_rdy_i | !is_store) &
                 !meu_busy_i & !meu_vld_o;

  // The head leaves after its last valid op issues
  assign last_slot = !both_vld | sel_q;

  // A bundle with no valid slot has nothing to issue and is dropped at once
  assign pop_o = (issue & last_slot) | (!empty_i & none_vld);

  // The tag is the bundle index extended by the slot number
  always_comb begin
    issue_op.tag        = {head_i.rob, sel};
    issue_op.ios_type   = cur_uop.ios_type;
    issue_op.ios_opcode = cur_uop.ios_opcode;
    issue_op.immediate  = cur_uop.immediate;
    issue_op.rs1        = cur_uop.rs1;
    issue_op.rs2        = cur_uop.rs2;
    issue_op.dest       = cur_uop.dest;
  end

  // Slot selector toggles only inside a two-op bundle
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i | flush_i) begin
      sel_q <= 1'b0;
    end else if (issue) begin
      sel_q <= both_vld & !sel_q;
    end
  end

  // Valid stays up until a cycle where the unit is idle and can capture it
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i | flush_i) begin
      meu_vld_o <= 1'b0;
    end else if (issue) begin
      meu_vld_o <= 1'b1;
    end else if (!meu_busy_i) begin
      meu_vld_o <= 1'b0;
    end
  end

  // Issued op payload
  always_ff @(posedge cpu_clk_i) begin
    if (issue) begin
      meu_op_o <= issue_op;
    end
  end

  // The unit reports busy from its own flop so this guards the round trip
  // An issued op must never be presented to a busy unit that would drop it
  a_no_issue_busy: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
    meu_vld_o |-> !meu_busy_i);

endmodule

// ==== reg_ready_table.sv ====
`timescale 1ns/1ps

module reg_ready_table import mem_sched_pkg::*; (
  input  logic              cpu_clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  // Rename time allocation marks a destination busy
  input  logic              alloc0_vld_i,
  input  logic [PREG_W-1:0] alloc0_preg_i,
  input  logic              alloc1_vld_i,
  input  logic [PREG_W-1:0] alloc1_preg_i,
  // Writeback marks a register ready again
  input  logic              wb0_vld_i,
  input  logic [PREG_W-1:0] wb0_preg_i,
  input  logic              wb1_vld_i,
  input  logic [PREG_W-1:0] wb1_preg_i,
  // Two combinational lookup ports
  input  logic [PREG_W-1:0] rd_a_idx_i,
  output logic              rd_a_rdy_o,
  input  logic [PREG_W-1:0] rd_b_idx_i,
  output logic              rd_b_rdy_o
);

  // One bit per physical register and a set bit means the value is ready
  logic [NUM_PREGS-1:0] ready_q;
  logic [NUM_PREGS-1:0] ready_d;

  // Writebacks are applied first
  // Allocations come after them so a same cycle allocation keeps the register busy
  always_comb begin
    ready_d = ready_q;
    if (wb0_vld_i) begin
      ready_d[wb0_preg_i] = 1'b1;
    end
    if (wb1_vld_i) begin
      ready_d[wb1_preg_i] = 1'b1;
    end
    if (alloc0_vld_i) begin
      ready_d[alloc0_preg_i] = 1'b0;
    end
    if (alloc1_vld_i) begin
      ready_d[alloc1_preg_i] = 1'b0;
    end
  end

  // A flush drops all in-flight producers so every register becomes ready
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i | flush_i) begin
      ready_q <= '1;
    end else begin
      ready_q <= ready_d;
    end
  end

  // Lookups see the state before this cycle's updates
  assign rd_a_rdy_o = ready_q[rd_a_idx_i];
  assign rd_b_rdy_o = ready_q[rd_b_idx_i];

endmodule

// ==== tb_mem_issue.sv ====
`timescale 1ns/1ps

module tb_mem_issue import mem_sched_pkg::*; ();

  localparam int unsigned SEED          = 32'h535f_94be;
  localparam int unsigned DRAIN_TIMEOUT = 400;
  localparam int unsigned STALL_CYCLES  = 30;

  logic              cpu_clk_i;
  logic              rst_i;
  logic              flush_i;
  logic              renamer_pkt_vld_i;
  mem_bundle_t       bundle_i;
  logic              full_o;
  logic              wb_vld_i;
  logic [PREG_W-1:0] wb_preg_i;
  logic              cmp_vld_o;
  meu_cmp_t          cmp_o;

  // Expected completions in program order and a mirror of the ready table
  meu_cmp_t             exp_q[$];
  logic [NUM_PREGS-1:0] model_rdy;
  int unsigned          n_cmp;
  int unsigned          n_dropped;
  int unsigned          rob_ctr;
  int unsigned          wb_scan;
  int unsigned          checks;
  int unsigned          errors;
  int unsigned          err_at_start;
  int unsigned          tests;
  int unsigned          tests_failed;

  mem_issue_top u_mem_issue_top (
    .cpu_clk_i         (cpu_clk_i),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .renamer_pkt_vld_i (renamer_pkt_vld_i),
    .bundle_i          (bundle_i),
    .full_o            (full_o),
    .wb_vld_i          (wb_vld_i),
    .wb_preg_i         (wb_preg_i),
    .cmp_vld_o         (cmp_vld_o),
    .cmp_o             (cmp_o)
  );

  always #4 cpu_clk_i = ~cpu_clk_i;

  task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected 0x%0h got 0x%0h", $time, what, exp, got);
    end
  endtask

  // Completion is a registered pulse, so the falling edge sees it exactly once
  task automatic check_completion();
    meu_cmp_t e;
    if (cmp_vld_o) begin
      n_cmp++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("At %0t a completion with tag 0x%0h arrived while no op was outstanding",
                 $time, cmp_o.tag);
      end else begin
        e = exp_q.pop_front();
        compare_value(cmp_o.tag, e.tag, "completion tag");
        compare_value(cmp_o.dest, e.dest, "completion dest");
        compare_value(cmp_o.store, e.store, "completion store flag");
        // A finished load frees its dest on the coming edge
        if (!e.store) model_rdy[e.dest] = 1'b1;
      end
    end
  endtask

  // One clock cycle of stimulus, driven at the falling edge
  task automatic step(input logic vld, input mem_bundle_t b, input logic wb_v,
                      input logic [PREG_W-1:0] wb_p, input logic fl);
    meu_cmp_t    e;
    int unsigned s;
    @(negedge cpu_clk_i);
    check_completion();
    renamer_pkt_vld_i = vld;
    bundle_i          = b;
    wb_vld_i          = wb_v;
    wb_preg_i         = wb_p;
    flush_i           = fl;
    if (fl) begin
      exp_q.delete();
      model_rdy = '1;
    end else begin
      if (wb_v) model_rdy[wb_p] = 1'b1;
      // Full is a flop, so its value here decides acceptance at the next edge
      if (vld && full_o) begin
        n_dropped++;
      end else if (vld) begin
        for (s = 0; s < 2; s++) begin
          if (b.slot[s].valid) begin
            e.tag   = TAG_W'({b.rob, s[0]});
            e.dest  = b.slot[s].dest;
            e.store = b.slot[s].ios_type[STORE_BIT];
            exp_q.push_back(e);
            // Allocation is applied after the clears, so it wins a conflict
            if (!e.store) model_rdy[e.dest] = 1'b0;
          end
        end
      end
    end
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) step(1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  function automatic mem_uop_t make_uop(input logic vld, input logic st,
                                        input logic [PREG_W-1:0] rs1,
                                        input logic [PREG_W-1:0] rs2,
                                        input logic [PREG_W-1:0] dest);
    mem_uop_t u;
    u                = '0;
    u.valid          = vld;
    u.rs1            = rs1;
    u.rs2            = rs2;
    u.dest           = dest;
    u.immediate      = $urandom;
    u.ios_opcode     = OPC_W'($urandom_range(0, 7));
    u.ios_type[STORE_BIT] = st;
    return u;
  endfunction

  task automatic offer(input mem_uop_t s0, input mem_uop_t s1);
    mem_bundle_t b;
    b.slot[0] = s0;
    b.slot[1] = s1;
    b.rob     = ROB_W'(rob_ctr);
    rob_ctr++;
    step(1'b1, b, 1'b0, '0, 1'b0);
  endtask

  // Registers come from a small pool so dependencies and stalls are common
  task automatic rand_bundle(output mem_bundle_t b);
    int unsigned s;
    for (s = 0; s < 2; s++) begin
      b.slot[s].rs1        = PREG_W'($urandom_range(0, 15));
      b.slot[s].rs2        = PREG_W'($urandom_range(0, 15));
      b.slot[s].dest       = PREG_W'($urandom_range(0, 15));
      b.slot[s].immediate  = $urandom;
      b.slot[s].ios_type   = TYPE_W'($urandom);
      b.slot[s].ios_opcode = OPC_W'($urandom);
      b.slot[s].valid      = ($urandom_range(0, 3) != 0);
    end
    b.rob = ROB_W'(rob_ctr);
    rob_ctr++;
  endtask

  // Chooses a register that the model holds busy, scanning from a rotating start
  task automatic pick_busy(output logic v, output logic [PREG_W-1:0] p);
    int unsigned k;
    int unsigned idx;
    v = 1'b0;
    p = '0;
    for (k = 0; k < NUM_PREGS; k++) begin
      idx = (wb_scan + k) % NUM_PREGS;
      if (!v && !model_rdy[idx]) begin
        v = 1'b1;
        p = PREG_W'(idx);
      end
    end
    wb_scan = (wb_scan + 1) % NUM_PREGS;
  endtask

  // Runs until every expected op completed; with allow_wb the busy registers get written back
  task automatic drain(input logic allow_wb);
    int unsigned       quiet;
    int unsigned       last;
    logic              wb_v;
    logic [PREG_W-1:0] wb_p;
    quiet = 0;
    while (exp_q.size() != 0 && quiet < DRAIN_TIMEOUT) begin
      last = n_cmp;
      wb_v = 1'b0;
      wb_p = '0;
      if (allow_wb) pick_busy(wb_v, wb_p);
      step(1'b0, '0, wb_v, wb_p, 1'b0);
      quiet = (n_cmp != last) ? 0 : quiet + 1;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout at %0t: %0d ops still had not completed after %0d quiet cycles",
               $time, exp_q.size(), DRAIN_TIMEOUT);
      // Flush so the next test starts from an empty pipe
      step(1'b0, '0, 1'b0, '0, 1'b1);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != err_at_start) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_at_start);
    end else begin
      $display("test %s: passed", name);
    end
    err_at_start = errors;
  endtask

  initial begin
    mem_bundle_t b;
    int unsigned i;
    int unsigned base;
    int unsigned drop0;
    void'($urandom(SEED));
    cpu_clk_i         = 1'b0;
    rst_i             = 1'b1;
    flush_i           = 1'b0;
    renamer_pkt_vld_i = 1'b0;
    bundle_i          = '0;
    wb_vld_i          = 1'b0;
    wb_preg_i         = '0;
    model_rdy         = '1;
    n_cmp             = 0;
    n_dropped         = 0;
    rob_ctr           = 0;
    wb_scan           = 0;
    checks            = 0;
    errors            = 0;
    err_at_start      = 0;
    tests             = 0;
    tests_failed      = 0;
    repeat (16) @(posedge cpu_clk_i);
    @(negedge cpu_clk_i);
    rst_i = 1'b0;
    compare_value(full_o, 1'b0, "full_o after reset");
    compare_value(cmp_vld_o, 1'b0, "cmp_vld_o after reset");

    // Random bundles and writebacks, then everything must retire in order
    for (i = 0; i < 300; i++) begin
      rand_bundle(b);
      step($urandom_range(0, 9) < 6, b, $urandom_range(0, 3) == 0,
           PREG_W'($urandom_range(0, 15)), 1'b0);
    end
    drain(1'b1);
    end_test("random_order");

    // Slot 0 only, slot 1 only, then both
    base = n_cmp;
    offer(make_uop(1, 0, 1, 2, 30), make_uop(0, 0, 0, 0, 0));
    offer(make_uop(0, 0, 0, 0, 0), make_uop(1, 0, 2, 3, 31));
    offer(make_uop(1, 0, 4, 5, 32), make_uop(1, 1, 1, 3, 0));
    drain(1'b0);
    compare_value(n_cmp - base, 4, "completions for slot patterns");
    end_test("slot_patterns");

    // Slot 1 allocates the register that slot 0 is waiting for
    base = n_cmp;
    offer(make_uop(1, 0, 40, 0, 41), make_uop(1, 0, 1, 0, 40));
    idle(STALL_CYCLES);
    compare_value(n_cmp - base, 0, "completions while load rs1 busy");
    step(1'b0, '0, 1'b1, 6'd40, 1'b0);
    drain(1'b0);
    // A store waits for rs2 as well
    base = n_cmp;
    offer(make_uop(1, 1, 2, 42, 0), make_uop(1, 0, 3, 0, 42));
    idle(STALL_CYCLES);
    compare_value(n_cmp - base, 0, "completions while store rs2 busy");
    step(1'b0, '0, 1'b1, 6'd42, 1'b0);
    drain(1'b0);
    // A load with a busy rs2 goes ahead
    offer(make_uop(1, 0, 4, 43, 44), make_uop(1, 0, 5, 0, 43));
    drain(1'b0);
    end_test("operand_stalls");

    // The head blocks on itself while the queue fills
    offer(make_uop(1, 0, 46, 0, 46), make_uop(0, 0, 0, 0, 0));
    drop0 = n_dropped;
    for (i = 0; i < 12; i++) begin
      rand_bundle(b);
      step(1'b1, b, 1'b0, '0, 1'b0);
    end
    compare_value(full_o, 1'b1, "full_o with blocked head");
    compare_value(n_dropped - drop0, 5, "bundles dropped while full");
    step(1'b0, '0, 1'b1, 6'd46, 1'b0);
    drain(1'b1);
    end_test("full_drop");

    // Nothing accepted before the flush may complete
    // Slot 0 enters the unit on the edge before the flush and slot 1 waits on its dest
    offer(make_uop(1, 0, 1, 0, 47), make_uop(1, 1, 47, 47, 0));
    for (i = 0; i < 2; i++) begin
      rand_bundle(b);
      step(1'b1, b, 1'b0, '0, 1'b0);
    end
    step(1'b0, '0, 1'b0, '0, 1'b1);
    base = n_cmp;
    idle(20);
    compare_value(n_cmp - base, 0, "completions after flush");
    // Register 47 was busy before the flush and is ready now
    offer(make_uop(1, 0, 47, 0, 48), make_uop(1, 1, 47, 47, 0));
    drain(1'b0);
    end_test("flush");

    // A load's completion alone releases a dependent load
    offer(make_uop(1, 0, 1, 0, 50), make_uop(0, 0, 0, 0, 0));
    offer(make_uop(1, 0, 50, 0, 51), make_uop(0, 0, 0, 0, 0));
    drain(1'b0);
    end_test("load_wakeup");

    idle(10);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
